/* src.f */
+incdir+include
verilog/mips_dbg_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/debug_unit.sv
verilog/imem_shared.sv
verilog/mini_mips_core.sv
verilog/mips_debug_top.sv
test/tb_mips_debug.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f src.f \
	--top-module tb_mips_debug \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* test/tb_mips_debug.sv */
`default_nettype none

`include "mips_dbg_params.svh"

module tb_mips_debug;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT = `MIPS_DBG_UART_CLKS_PER_BIT;
	localparam int STEP_LIMIT = 2000;

	logic clk = 1'b0;
	logic reset;
	logic rx;
	logic tx;
	logic core_running;

	// host copy of the instruction ram, kept across loads
	mips_dbg_pkg::word_t mem_img [256];
	logic [7:0]          reply_q [$];
	int                  reply_count = 0;
	int                  errors = 0;
	time                 deadline = 64'd2000;

	mips_debug_top UUT (
		.clk          (clk),
		.reset        (reset),
		.rx           (rx),
		.tx           (tx),
		.core_running (core_running)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	function automatic mips_dbg_pkg::word_t make_instr(input logic [3:0] op, input int rd,
			input int rs, input int rt, input int imm);
		return {op, 1'b0, 3'(rd), 1'b0, 3'(rs), 1'b0, 3'(rt), 16'(imm)};
	endfunction

	// ADDI, ADD, SUB or a NOP opcode, other fields random
	function automatic mips_dbg_pkg::word_t random_instr();
		mips_dbg_pkg::word_t w;
		w = $urandom;
		case ($urandom % 4)
			0:       w[31:28] = `MIPS_DBG_OP_ADDI;
			1:       w[31:28] = `MIPS_DBG_OP_ADD;
			2:       w[31:28] = `MIPS_DBG_OP_SUB;
			default: w[31:28] = 4'(5 + $urandom % 11);
		endcase
		return w;
	endfunction

	//////////////////////////////////////////////////
	// isa reference model
	//////////////////////////////////////////////////
	function automatic void model_run(output logic [7:0] hpc, output logic [31:0] r1,
			output int steps);
		logic [31:0] regs [8];
		logic [31:0] ins;
		logic [31:0] imm;
		logic [31:0] val;
		logic [7:0]  pc;
		logic        wr;
		logic        done;
		for (int i = 0; i < 8; i++)
			regs[i] = 32'd0;
		pc = 8'd0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < STEP_LIMIT) begin
			ins = mem_img[pc];
			imm = {{16{ins[15]}}, ins[15:0]};
			val = 32'd0;
			wr = 1'b0;
			steps++;
			case (ins[31:28])
				`MIPS_DBG_OP_HALT: done = 1'b1;
				`MIPS_DBG_OP_ADDI: begin
					val = regs[ins[22:20]] + imm;
					wr = 1'b1;
				end
				`MIPS_DBG_OP_ADD: begin
					val = regs[ins[22:20]] + regs[ins[18:16]];
					wr = 1'b1;
				end
				`MIPS_DBG_OP_SUB: begin
					val = regs[ins[22:20]] - regs[ins[18:16]];
					wr = 1'b1;
				end
				default: ;
			endcase
			// r0 stays zero
			if (wr && ins[26:24] != 3'd0)
				regs[ins[26:24]] = val;
			// branch target wraps at 256 words
			if (ins[31:28] == `MIPS_DBG_OP_BNE && regs[ins[22:20]] != regs[ins[18:16]])
				pc = pc + 8'd1 + imm[7:0];
			else if (!done)
				pc = pc + 8'd1;
		end
		hpc = pc;
		r1 = regs[1];
	endfunction

	//////////////////////////////////////////////////
	// host side of the serial link
	//////////////////////////////////////////////////
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (BIT - 1) @(posedge clk);
		end
	endtask

	// decode reply frames, sampled mid bit on the falling edge
	initial begin : tx_monitor
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				// core still enabled when the reply starts
				if (reply_count % 5 == 0)
					check_eq("core_running at reply", 32'd1, 32'(core_running));
				repeat (BIT / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT) @(negedge clk);
					b[i] = tx;
				end
				repeat (BIT) @(negedge clk);
				check_eq("tx stop bit", 32'd1, 32'(tx));
				reply_q.push_back(b);
				reply_count++;
			end
		end
	end

	// load mem_img[0..n-1], wait for the five reply bytes
	task automatic run_test(input string name, input int n);
		logic [7:0]  exp_pc;
		logic [31:0] exp_r1;
		logic [7:0]  got_pc;
		logic [31:0] got_r1;
		int          steps;
		model_run(exp_pc, exp_r1, steps);
		if (steps >= STEP_LIMIT) begin
			$display("reference model for %s never reached HALT", name);
			stop_with_failure();
		end
		@(negedge clk);
		check_eq({name, " core_running before load"}, 32'd0, 32'(core_running));
		// length, words and reply at 12 bit times a byte, plus the run
		deadline = $time + 64'(4 * ((6 + 4 * n) * 12 * BIT + 4 * steps));
		send_byte(8'(n));
		for (int i = 0; i < n; i++)
			for (int j = 0; j < 4; j++)
				send_byte(mem_img[i][8 * j +: 8]);
		while (reply_q.size() < 5)
			@(negedge clk);
		got_pc = reply_q.pop_front();
		got_r1 = 32'd0;
		for (int j = 0; j < 4; j++)
			got_r1[8 * j +: 8] = reply_q.pop_front();
		check_eq({name, " halt_pc"}, 32'(exp_pc), 32'(got_pc));
		check_eq({name, " r1"}, exp_r1, got_r1);
		// run drops at the end of the last stop bit
		repeat (BIT) @(negedge clk);
		check_eq({name, " core_running after reply"}, 32'd0, 32'(core_running));
	endtask

	initial begin : watchdog
		while ($time <= deadline)
			@(posedge clk);
		$display("timeout, no reply arrived from the DUT");
		stop_with_failure();
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin : main
		int len;
		void'($urandom(32'hffa4_37e0));
		rx = 1'b1;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// straight line arithmetic
		mem_img[0] = make_instr(`MIPS_DBG_OP_ADDI, 2, 0, 0, 100);
		mem_img[1] = make_instr(`MIPS_DBG_OP_ADDI, 3, 0, 0, -42);
		mem_img[2] = make_instr(`MIPS_DBG_OP_ADD, 4, 2, 3, 0);
		mem_img[3] = make_instr(`MIPS_DBG_OP_SUB, 1, 4, 3, 0);
		mem_img[4] = make_instr(`MIPS_DBG_OP_SUB, 1, 1, 3, 7);
		mem_img[5] = make_instr(`MIPS_DBG_OP_HALT, 0, 0, 0, 0);
		run_test("straight", 6);

		// r1 += 3, five times
		mem_img[0] = make_instr(`MIPS_DBG_OP_ADDI, 2, 0, 0, 5);
		mem_img[1] = make_instr(`MIPS_DBG_OP_ADDI, 1, 0, 0, 0);
		mem_img[2] = make_instr(`MIPS_DBG_OP_ADDI, 1, 1, 0, 3);
		mem_img[3] = make_instr(`MIPS_DBG_OP_ADDI, 2, 2, 0, -1);
		mem_img[4] = make_instr(`MIPS_DBG_OP_BNE, 0, 2, 0, -3);
		mem_img[5] = make_instr(`MIPS_DBG_OP_HALT, 0, 0, 0, 0);
		run_test("countdown", 6);

		// leftover r1 and r2 would show up here
		mem_img[0] = make_instr(`MIPS_DBG_OP_ADD, 1, 1, 2, 0);
		mem_img[1] = make_instr(`MIPS_DBG_OP_ADDI, 1, 1, 0, 9);
		mem_img[2] = make_instr(`MIPS_DBG_OP_HALT, 0, 0, 0, 0);
		run_test("reload", 3);

		mem_img[0] = make_instr(`MIPS_DBG_OP_ADDI, 0, 0, 0, 55);
		mem_img[1] = make_instr(`MIPS_DBG_OP_ADD, 0, 0, 0, 0);
		mem_img[2] = make_instr(`MIPS_DBG_OP_ADD, 1, 0, 0, 0);
		mem_img[3] = make_instr(`MIPS_DBG_OP_HALT, 0, 0, 0, 0);
		run_test("r0 write", 4);

		for (int t = 0; t < 20; t++) begin
			len = 2 + int'($urandom % 14);
			for (int i = 0; i < len - 1; i++)
				mem_img[i] = random_instr();
			mem_img[len - 1] = make_instr(`MIPS_DBG_OP_HALT, 0, 0, 0, 0);
			run_test($sformatf("random %0d", t), len);
		end

		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

/* verilog/mips_debug_top.sv */
`default_nettype none

module mips_debug_top (
	input  wire  clk,
	input  wire  reset,
	input  wire  rx,
	output logic tx,
	output logic core_running
);

	// uart to debug unit
	mips_dbg_pkg::byte_t      rx_data;
	logic                     rx_done;
	mips_dbg_pkg::byte_t      tx_data;
	logic                     tx_start;
	logic                     tx_done;

	// ram write port
	logic                     wr_en;
	mips_dbg_pkg::imem_addr_t wr_addr;
	mips_dbg_pkg::word_t      wr_data;

	// fetch port
	logic                     fetch_req;
	logic                     fetch_grant;
	logic                     fetch_valid;
	mips_dbg_pkg::imem_addr_t fetch_addr;
	mips_dbg_pkg::word_t      fetch_data;

	// core status
	logic                     run;
	logic                     halt;
	mips_dbg_pkg::imem_addr_t halt_pc;
	mips_dbg_pkg::word_t      result;

	// led shows the run enable
	assign core_running = run;

	uart_rx u_uart_rx (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	debug_unit u_debug_unit (
		.clk      (clk),
		.reset    (reset),
		.rx_data  (rx_data),
		.rx_done  (rx_done),
		.tx_done  (tx_done),
		.halt     (halt),
		.halt_pc  (halt_pc),
		.result   (result),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.wr_en    (wr_en),
		.run      (run),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	imem_shared u_imem_shared (
		.clk         (clk),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_grant (fetch_grant),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data)
	);

	mini_mips_core u_core (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.fetch_grant (fetch_grant),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.halt_pc     (halt_pc),
		.halt        (halt),
		.result      (result)
	);

endmodule

`default_nettype wire

/* verilog/mini_mips_core.sv */
`default_nettype none

`include "mips_dbg_params.svh"

module mini_mips_core (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      run,
	input  wire                      fetch_grant,
	input  wire                      fetch_valid,
	input  wire mips_dbg_pkg::word_t fetch_data,
	output logic                     fetch_req,
	output mips_dbg_pkg::imem_addr_t fetch_addr,
	output mips_dbg_pkg::imem_addr_t halt_pc,
	output logic                     halt,
	output mips_dbg_pkg::word_t      result
);

	mips_dbg_pkg::core_state_t state;
	mips_dbg_pkg::imem_addr_t  pc;
	mips_dbg_pkg::word_t       regs [8];

	// decode fields
	logic [3:0]                op;
	mips_dbg_pkg::reg_idx_t    rd;
	mips_dbg_pkg::reg_idx_t    rs;
	mips_dbg_pkg::reg_idx_t    rt;
	mips_dbg_pkg::word_t       imm_ext;
	mips_dbg_pkg::word_t       rs_val;
	mips_dbg_pkg::word_t       rt_val;
	mips_dbg_pkg::word_t       alu_val;
	mips_dbg_pkg::imem_addr_t  next_pc;
	logic                      wr_reg;
	logic                      is_halt;

	assign op      = fetch_data[31:28];
	assign rd      = fetch_data[26:24];
	assign rs      = fetch_data[22:20];
	assign rt      = fetch_data[18:16];
	assign imm_ext = {{16{fetch_data[15]}}, fetch_data[15:0]};
	// r0 reads zero
	assign rs_val  = (rs == 3'd0) ? '0 : regs[rs];
	assign rt_val  = (rt == 3'd0) ? '0 : regs[rt];

	//////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////
	always_comb begin
		alu_val = '0;
		wr_reg  = 1'b0;
		is_halt = 1'b0;
		next_pc = pc + 8'd1;
		case (op)
			// pc stays on the halt itself
			`MIPS_DBG_OP_HALT: begin
				is_halt = 1'b1;
				next_pc = pc;
			end
			`MIPS_DBG_OP_ADDI: begin
				alu_val = rs_val + imm_ext;
				wr_reg  = 1'b1;
			end
			`MIPS_DBG_OP_ADD: begin
				alu_val = rs_val + rt_val;
				wr_reg  = 1'b1;
			end
			`MIPS_DBG_OP_SUB: begin
				alu_val = rs_val - rt_val;
				wr_reg  = 1'b1;
			end
			// offset wraps modulo ram size
			`MIPS_DBG_OP_BNE: begin
				if (rs_val != rt_val)
					next_pc = pc + 8'd1 + fetch_data[7:0];
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		// run low holds the core cleared
		if (reset || !run) begin
			state <= mips_dbg_pkg::IDLE;
			pc    <= '0;
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else begin
			case (state)
				mips_dbg_pkg::IDLE: state <= mips_dbg_pkg::FETCH;
				mips_dbg_pkg::FETCH: begin
					if (fetch_grant)
						state <= mips_dbg_pkg::EXEC;
				end
				mips_dbg_pkg::EXEC: begin
					if (fetch_valid) begin
						pc <= next_pc;
						// r0 writes dropped
						if (wr_reg && rd != 3'd0)
							regs[rd] <= alu_val;
						state <= is_halt ? mips_dbg_pkg::HALTED : mips_dbg_pkg::FETCH;
					end
				end
				default: state <= mips_dbg_pkg::HALTED;
			endcase
		end
	end

	assign fetch_req  = (state == mips_dbg_pkg::FETCH);
	assign fetch_addr = pc;
	assign halt       = (state == mips_dbg_pkg::HALTED);
	assign halt_pc    = pc;
	assign result     = regs[1];

	// read data lands in the cycle after the grant
	a_data_after_grant: assert property (@(posedge clk) disable iff (reset || !run)
		state == mips_dbg_pkg::EXEC |-> fetch_valid);

endmodule

`default_nettype wire

/* verilog/imem_shared.sv */
`default_nettype none

`include "mips_dbg_params.svh"

module imem_shared (
	input  wire                           clk,
	input  wire                           wr_en,
	input  wire mips_dbg_pkg::imem_addr_t wr_addr,
	input  wire mips_dbg_pkg::word_t      wr_data,
	input  wire                           fetch_req,
	input  wire mips_dbg_pkg::imem_addr_t fetch_addr,
	output logic                          fetch_grant,
	output logic                          fetch_valid,
	output mips_dbg_pkg::word_t           fetch_data
);

	// single port, one access per cycle
	mips_dbg_pkg::word_t mem [`MIPS_DBG_IMEM_DEPTH];

	//////////////////////////////////////////////////
	// arbiter
	//////////////////////////////////////////////////

	// writer has priority, fetcher waits
	assign fetch_grant = fetch_req && !wr_en;

	// valid trails the grant by one cycle
	always_ff @(posedge clk) begin
		fetch_valid <= fetch_grant;
	end

	//////////////////////////////////////////////////
	// ram port
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		else if (fetch_grant)
			fetch_data <= mem[fetch_addr];
	end

	// a fetch that loses to a write is served next cycle
	a_fetch_not_starved: assert property (@(posedge clk)
		fetch_req && !fetch_grant |=> fetch_grant);

endmodule

`default_nettype wire

/* verilog/debug_unit.sv */
`default_nettype none

module debug_unit (
	input  wire                           clk,
	input  wire                           reset,
	input  wire mips_dbg_pkg::byte_t      rx_data,
	input  wire                           rx_done,
	input  wire                           tx_done,
	input  wire                           halt,
	input  wire mips_dbg_pkg::imem_addr_t halt_pc,
	input  wire mips_dbg_pkg::word_t      result,
	output mips_dbg_pkg::byte_t           tx_data,
	output logic                          tx_start,
	output logic                          wr_en,
	output logic                          run,
	output mips_dbg_pkg::imem_addr_t      wr_addr,
	output mips_dbg_pkg::word_t           wr_data
);

	mips_dbg_pkg::dbg_state_t state;
	// program length in words
	mips_dbg_pkg::byte_t      len;
	mips_dbg_pkg::imem_addr_t word_cnt;
	logic [1:0]               byte_cnt;
	// captured at halt
	mips_dbg_pkg::imem_addr_t pc_q;
	mips_dbg_pkg::word_t      result_q;
	// 0 pc, 1..4 result bytes
	logic [2:0]               send_idx;
	logic                     in_flight;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= mips_dbg_pkg::LOAD_LEN;
			word_cnt <= '0;
			byte_cnt <= '0;
			send_idx <= '0;
			run      <= 1'b0;
			wr_en    <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			wr_en    <= 1'b0;
			tx_start <= 1'b0;
			case (state)
				mips_dbg_pkg::LOAD_LEN: begin
					// zero length ignored
					if (rx_done && rx_data != 8'd0) begin
						word_cnt <= '0;
						byte_cnt <= '0;
						state    <= mips_dbg_pkg::LOAD_WORD;
					end
				end
				mips_dbg_pkg::LOAD_WORD: begin
					if (rx_done) begin
						byte_cnt <= byte_cnt + 2'd1;
						// fourth byte completes the word
						if (byte_cnt == 2'd3) begin
							wr_en    <= 1'b1;
							word_cnt <= word_cnt + 8'd1;
							if (word_cnt == len - 8'd1)
								state <= mips_dbg_pkg::RUN;
						end
					end
				end
				mips_dbg_pkg::RUN: begin
					// one cycle after the last write
					run <= 1'b1;
					if (halt) begin
						send_idx <= '0;
						state    <= mips_dbg_pkg::REPORT;
					end
				end
				mips_dbg_pkg::REPORT: begin
					tx_start <= 1'b1;
					state    <= mips_dbg_pkg::SEND_WAIT;
				end
				mips_dbg_pkg::SEND_WAIT: begin
					if (tx_done) begin
						if (send_idx == 3'd4) begin
							// report done, core back to reset
							run   <= 1'b0;
							state <= mips_dbg_pkg::LOAD_LEN;
						end else begin
							send_idx <= send_idx + 3'd1;
							state    <= mips_dbg_pkg::REPORT;
						end
					end
				end
				default: state <= mips_dbg_pkg::LOAD_LEN;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		case (state)
			mips_dbg_pkg::LOAD_LEN: begin
				if (rx_done)
					len <= rx_data;
			end
			mips_dbg_pkg::LOAD_WORD: begin
				// lsb first, word fills from the top
				if (rx_done) begin
					wr_data <= {rx_data, wr_data[31:8]};
					wr_addr <= word_cnt;
				end
			end
			mips_dbg_pkg::RUN: begin
				if (halt) begin
					pc_q     <= halt_pc;
					result_q <= result;
				end
			end
			mips_dbg_pkg::REPORT: begin
				case (send_idx)
					3'd0:    tx_data <= pc_q;
					3'd1:    tx_data <= result_q[7:0];
					3'd2:    tx_data <= result_q[15:8];
					3'd3:    tx_data <= result_q[23:16];
					default: tx_data <= result_q[31:24];
				endcase
			end
			default: ;
		endcase
	end

	// byte on the wire between start and done
	always_ff @(posedge clk) begin
		if (reset)
			in_flight <= 1'b0;
		else if (tx_start)
			in_flight <= 1'b1;
		else if (tx_done)
			in_flight <= 1'b0;
	end

	a_no_start_in_flight: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !in_flight);

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`default_nettype none

`include "mips_dbg_params.svh"

module uart_tx (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      tx_start,
	input  wire mips_dbg_pkg::byte_t tx_data,
	output logic                     tx,
	output logic                     tx_done
);

	localparam int CLKS = `MIPS_DBG_UART_CLKS_PER_BIT;
	localparam int CW = $clog2(CLKS);

	logic          busy;
	// stop, data, start; bit 0 on the line
	logic [9:0]    shift;
	logic [3:0]    bit_cnt;
	logic [CW-1:0] clk_cnt;

	// line idles high outside a frame
	assign tx = busy ? shift[0] : 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				// start ignored while busy
				if (tx_start) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
					clk_cnt <= '0;
				end
			end else if (clk_cnt == CW'(CLKS - 1)) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					// end of stop bit
					busy    <= 1'b0;
					tx_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && tx_start)
			shift <= {1'b1, tx_data, 1'b0};
		else if (busy && clk_cnt == CW'(CLKS - 1))
			shift <= {1'b1, shift[9:1]};
	end

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`default_nettype none

`include "mips_dbg_params.svh"

module uart_rx (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 rx,
	output mips_dbg_pkg::byte_t rx_data,
	output logic                rx_done
);

	localparam int CLKS = `MIPS_DBG_UART_CLKS_PER_BIT;
	localparam int CW = $clog2(CLKS);

	logic          rx_meta;
	logic          rx_sync;
	logic          busy;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]    bit_cnt;
	logic [CW-1:0] clk_cnt;

	// two flops against metastability, idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (!busy) begin
				clk_cnt <= '0;
				bit_cnt <= '0;
				// falling edge starts a frame
				if (!rx_sync)
					busy <= 1'b1;
			end else if (bit_cnt == 4'd0) begin
				// half a bit to reach mid start bit
				if (clk_cnt == CW'(CLKS / 2 - 1)) begin
					clk_cnt <= '0;
					if (rx_sync)
						busy <= 1'b0;
					else
						bit_cnt <= 4'd1;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end else if (clk_cnt == CW'(CLKS - 1)) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					// low stop bit is a framing error, byte dropped
					rx_done <= rx_sync;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits, lsb first
	always_ff @(posedge clk) begin
		if (busy && bit_cnt != 4'd0 && bit_cnt != 4'd9 && clk_cnt == CW'(CLKS - 1))
			rx_data <= {rx_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

/* verilog/mips_dbg_pkg.sv */
`default_nettype none

package mips_dbg_pkg;

	// instruction or register value
	typedef logic [31:0] word_t;
	// one uart payload
	typedef logic [7:0] byte_t;
	// ram address, also the pc
	typedef logic [7:0] imem_addr_t;
	// register file index
	typedef logic [2:0] reg_idx_t;

	// debug unit flow
	typedef enum logic [2:0] {
		LOAD_LEN,
		LOAD_WORD,
		RUN,
		REPORT,
		SEND_WAIT
	} dbg_state_t;

	// core sequencing
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		EXEC,
		HALTED
	} core_state_t;

endpackage

`default_nettype wire

/* include/mips_dbg_params.svh */
`ifndef MIPS_DBG_PARAMS_SVH
`define MIPS_DBG_PARAMS_SVH

//////////////////////////////////////////////////
// serial link
//////////////////////////////////////////////////

// clocks per serial bit, kept short for simulation
`define MIPS_DBG_UART_CLKS_PER_BIT 16

// instruction ram words
`define MIPS_DBG_IMEM_DEPTH 256

//////////////////////////////////////////////////
// opcodes, bits 31..28 of an instruction
//////////////////////////////////////////////////
`define MIPS_DBG_OP_HALT 4'd0
`define MIPS_DBG_OP_ADDI 4'd1
`define MIPS_DBG_OP_ADD 4'd2
`define MIPS_DBG_OP_SUB 4'd3
`define MIPS_DBG_OP_BNE 4'd4

`endif
